// ==== ioRegisterMap.sv ====
/*
 * I/O register map
 * Decodes bus accesses into peripheral strobes, raises stall on
 * blocking UART accesses and builds the combinational read word
 */

`timescale 1ns/100ps

module ioRegisterMap (
	input  logic sel,
	input  logic [larvaIoPkg::IO_ADDR_W-1:0] addr,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	output logic [31:0] rdata,
	output logic stall,
	uartRegsIf.regMap uart,
	output logic dutyWrite,
	output logic [larvaIoPkg::PWM_W-1:0] dutyData,
	input  logic pwmIrq,
	input  logic [larvaIoPkg::GPIN_W-1:0] gpin,
	output logic enableWrite,
	output logic vectorWrite,
	output logic [larvaIoPkg::VEC_IDX_W-1:0] vectorIndex,
	output logic [larvaIoPkg::VEC_W-1:0] writeWord,
	input  logic [larvaIoPkg::NUM_IRQ-1:0] irqEnable
);
	import larvaIoPkg::*;

	logic [BLK_W-1:0] block;
	logic uartSel, pwmSel, irqSel;
	logic uartDataRd, uartDataWr;
	logic isVector;
	logic [ST_PWM_IRQ:0] status;

	////////////////////////////////////////////////////////////
	// Address decode
	assign block   = addr[IO_ADDR_W-1 -: BLK_W];
	assign uartSel = sel & (block == BLK_UART);
	assign pwmSel  = sel & (block == BLK_PWM);
	assign irqSel  = sel & (block == BLK_IRQ);
	assign isVector = addr[IRQ_REG_VECTOR];

	assign uartDataRd = uartSel & ~addr[UART_REG_STATUS] & (wstrb == 4'b0000);  // Pure read
	assign uartDataWr = uartSel & ~addr[UART_REG_STATUS] & wstrb[0];

	// Hold the master on empty rx or busy tx
	assign stall = (uartDataRd & ~uart.rxValid) | (uartDataWr & ~uart.txReady);

	////////////////////////////////////////////////////////////
	// Write and read strobes, all dropped while stalled
	assign uart.txWrite = uartDataWr & ~stall;
	assign uart.rxRead  = uartDataRd & ~stall;
	assign uart.txData  = wdata[7:0];

	assign dutyWrite = pwmSel & wstrb[0] & ~stall;
	assign dutyData  = wdata[PWM_W-1:0];

	assign enableWrite = irqSel & ~isVector & wstrb[0] & ~stall;
	assign vectorWrite = irqSel & isVector & (&wstrb) & ~stall;  // Full word only
	assign vectorIndex = addr[VEC_IDX_W-1:0];
	// Vector word drops the two low bits, enables sit at bit 0
	assign writeWord = isVector ? wdata[31:2] : VEC_W'(wdata[NUM_IRQ-1:0]);

	////////////////////////////////////////////////////////////
	// Read word
	always_comb begin
		status = '0;
		status[ST_RX_VALID]  = uart.rxValid;
		status[ST_TX_READY]  = uart.txReady;
		status[ST_FRAME_ERR] = uart.rxFrameErr;
		status[ST_OVERRUN]   = uart.rxOverrun;
		status[ST_PWM_IRQ]   = pwmIrq;
	end

	always_comb begin
		rdata = '0;  // Unmapped blocks read zero
		if (uartSel)
			rdata = addr[UART_REG_STATUS] ? 32'(status) : 32'(uart.rxData);
		else if (pwmSel)
			rdata = 32'(gpin);  // Input port lives in the PWM block
		else if (irqSel)
			rdata = 32'(irqEnable);
	end

endmodule

// ==== irqController.sv ====
/*
 * Interrupt controller
 * Enable register, four-entry vector table, fixed priority select
 */

`timescale 1ns/100ps

module irqController (
	input  logic clk,
	input  logic reset,
	input  logic enableWrite,
	input  logic vectorWrite,
	input  logic [larvaIoPkg::VEC_IDX_W-1:0] vectorIndex,
	input  logic [larvaIoPkg::VEC_W-1:0] writeWord,
	input  logic rxValid,
	input  logic txReady,
	input  logic pwmIrq,
	input  logic trap,
	output logic [larvaIoPkg::NUM_IRQ-1:0] irqEnable,
	output logic irq,
	output logic [larvaIoPkg::VEC_W-1:0] ivector
);
	import larvaIoPkg::*;

	logic [VEC_W-1:0] vectorTable [NUM_VECTORS];
	logic [NUM_IRQ-1:0] pending;
	logic [VEC_IDX_W-1:0] vecSel;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			irqEnable <= '0;
		else if (enableWrite)
			irqEnable <= writeWord[NUM_IRQ-1:0];
	end

	always_ff @(posedge clk) begin
		if (vectorWrite)
			vectorTable[vectorIndex] <= writeWord;
	end

	// Masked sources: bit 0 rx, bit 1 tx, bit 2 pwm
	assign pending = irqEnable & {pwmIrq, txReady, rxValid};

	// Fixed priority, trap first
	assign vecSel = trap       ? 2'd0 :
	                pending[0] ? 2'd1 :
	                pending[1] ? 2'd2 : 2'd3;

	assign ivector = vectorTable[vecSel];
	assign irq     = (|pending) | trap;

endmodule

// ==== larvaIoPkg.sv ====
/*
 * Register map of the peripheral I/O window
 * Block codes, register selects, status bit layout and field widths
 */

package larvaIoPkg;

	////////////////////////////////////////////////////////////
	// Address fields
	localparam int IO_ADDR_W = 6;        // Word address, byte bits 7..2
	localparam int BLK_W     = 3;        // Top address bits pick the block

	localparam logic [BLK_W-1:0] BLK_UART = 3'd0;  // Byte offset 0x00
	localparam logic [BLK_W-1:0] BLK_PWM  = 3'd1;  // Byte offset 0x20
	localparam logic [BLK_W-1:0] BLK_IRQ  = 3'd7;  // Byte offset 0xE0

	localparam int UART_REG_STATUS = 0;  // Byte bit 2: status word, else data byte
	localparam int IRQ_REG_VECTOR  = 2;  // Byte bit 4: vector table, else enables

	////////////////////////////////////////////////////////////
	// UART status word
	localparam int ST_RX_VALID  = 0;
	localparam int ST_TX_READY  = 1;
	localparam int ST_FRAME_ERR = 2;
	localparam int ST_OVERRUN   = 3;
	localparam int ST_PWM_IRQ   = 4;

	////////////////////////////////////////////////////////////
	// Interrupts
	localparam int NUM_IRQ     = 3;                     // rx, tx, pwm
	localparam int NUM_VECTORS = 4;                     // trap, rx, tx, pwm
	localparam int VEC_IDX_W   = $clog2(NUM_VECTORS);   // Table index
	localparam int VEC_W       = 30;                    // Word aligned vector

	// PWM and input port
	localparam int PWM_W = 8;
	localparam logic [PWM_W-1:0] PWM_TOP = 8'd180;      // 181 steps per period
	localparam int GPIN_W = 4;

endpackage

// ==== larvaPeripherals.sv ====
/*
 * Peripheral block of the microcontroller
 * UART, PWM, input port and interrupt controller on one I/O window
 */

`timescale 1ns/100ps

module larvaPeripherals (
	input  logic clk,
	input  logic reset,
	// Bus side
	input  logic sel,
	input  logic [larvaIoPkg::IO_ADDR_W-1:0] addr,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	output logic [31:0] rdata,
	output logic stall,
	// Pins
	input  logic rxd,
	output logic txd,
	output logic pwmOut,
	input  logic [larvaIoPkg::GPIN_W-1:0] gpin,
	// CPU interrupt side
	input  logic trap,
	output logic irq,
	output logic [larvaIoPkg::VEC_W-1:0] ivector
);
	import larvaIoPkg::*;

	logic dutyWrite;
	logic [PWM_W-1:0] dutyData;
	logic pwmIrq;
	logic enableWrite, vectorWrite;
	logic [VEC_IDX_W-1:0] vectorIndex;
	logic [VEC_W-1:0] writeWord;
	logic [NUM_IRQ-1:0] irqEnable;

	uartRegsIf uart ();

	////////////////////////////////////////////////////////////
	// Register map
	ioRegisterMap regMap (
		.sel(sel), .addr(addr), .wdata(wdata), .wstrb(wstrb),
		.rdata(rdata), .stall(stall), .uart(uart.regMap),
		.dutyWrite(dutyWrite), .dutyData(dutyData), .pwmIrq(pwmIrq), .gpin(gpin),
		.enableWrite(enableWrite), .vectorWrite(vectorWrite),
		.vectorIndex(vectorIndex), .writeWord(writeWord), .irqEnable(irqEnable)
	);

	////////////////////////////////////////////////////////////
	// Peripherals
	uartTx uartTx0 (.clk(clk), .reset(reset), .uart(uart.transmitter), .txd(txd));
	uartRx uartRx0 (.clk(clk), .reset(reset), .uart(uart.receiver), .rxd(rxd));

	pwmGenerator pwm0 (
		.clk(clk), .reset(reset), .dutyWrite(dutyWrite), .dutyData(dutyData),
		.pwmOut(pwmOut), .pwmIrq(pwmIrq)
	);

	irqController irq0 (
		.clk(clk), .reset(reset), .enableWrite(enableWrite),
		.vectorWrite(vectorWrite), .vectorIndex(vectorIndex), .writeWord(writeWord),
		.rxValid(uart.rxValid), .txReady(uart.txReady), .pwmIrq(pwmIrq),
		.trap(trap), .irqEnable(irqEnable), .irq(irq), .ivector(ivector)
	);

endmodule

// ==== larvaPeripherals_sva.sv ====
/*
 * Bound assertions on the peripheral block ports
 */

`timescale 1ns/100ps

module larvaPeripherals_sva (
	input logic clk,
	input logic reset,
	input logic sel,
	input logic [larvaIoPkg::IO_ADDR_W-1:0] addr,
	input logic [31:0] rdata,
	input logic stall,
	input logic txd,
	input logic trap,
	input logic irq
);
	import larvaIoPkg::*;

	logic statusRead, enableRead;

	assign statusRead = sel && addr[IO_ADDR_W-1 -: BLK_W] == BLK_UART && addr[UART_REG_STATUS];
	assign enableRead = sel && addr[IO_ADDR_W-1 -: BLK_W] == BLK_IRQ && !addr[IRQ_REG_VECTOR];

	// Stall only while the master accesses
	stallNeedsSel: assert property (@(posedge clk) disable iff (reset) !sel |-> !stall)
		else $error("stall high without sel");

	// Idle transmitter keeps the line high
	txIdleHigh: assert property (@(posedge clk) disable iff (reset)
		statusRead && rdata[ST_TX_READY] |-> txd)
		else $error("txd low while status shows tx ready");

	// With all enables off only trap reaches irq
	irqOnlyTrap: assert property (@(posedge clk) disable iff (reset)
		enableRead && rdata[NUM_IRQ-1:0] == '0 |-> irq == trap)
		else $error("irq differs from trap with enables zero");

endmodule

bind larvaPeripherals larvaPeripherals_sva sva0 (
	.clk(clk), .reset(reset), .sel(sel), .addr(addr), .rdata(rdata),
	.stall(stall), .txd(txd), .trap(trap), .irq(irq)
);

// ==== pwmGenerator.sv ====
/*
 * PWM generator, 181 steps per period
 * Double-buffered duty and a period interrupt flag
 */

`timescale 1ns/100ps

module pwmGenerator (
	input  logic clk,
	input  logic reset,
	input  logic dutyWrite,
	input  logic [larvaIoPkg::PWM_W-1:0] dutyData,
	output logic pwmOut,
	output logic pwmIrq
);
	import larvaIoPkg::*;

	logic [PWM_W-1:0] count;
	logic [PWM_W-1:0] holdDuty;    // Written by the bus
	logic [PWM_W-1:0] activeDuty;  // Used this period
	logic terminal, zero;

	assign terminal = (count == PWM_TOP);
	assign zero     = (count == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count      <= '0;
			holdDuty   <= '0;
			activeDuty <= '0;
			pwmOut     <= 1'b0;
			pwmIrq     <= 1'b0;
		end else begin
			count <= terminal ? '0 : count + 1'b1;
			if (dutyWrite)
				holdDuty <= dutyData;
			if (terminal)
				activeDuty <= holdDuty;  // New duty from next period
			// Clear on match wins over set at zero
			pwmOut <= (count == activeDuty) ? 1'b0 : (zero ? 1'b1 : pwmOut);
			pwmIrq <= zero ? 1'b1 : (dutyWrite ? 1'b0 : pwmIrq);
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_larvaPeripherals -f vlog.f -o simLarva
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simLarva > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

// ==== tb_larvaPeripherals.sv ====
/*
 * Testbench for the peripheral block
 * LCG stimulus on bus and pins, checked against a reference model
 */

`timescale 1ns/100ps

module tb_larvaPeripherals;
	import larvaIoPkg::*;
	import uartPkg::*;

	// Word addresses in the I/O window
	localparam logic [IO_ADDR_W-1:0] UART_DATA = {BLK_UART, 3'b000};
	localparam logic [IO_ADDR_W-1:0] UART_STAT = {BLK_UART, 3'b001};  // Status on bit 0
	localparam logic [IO_ADDR_W-1:0] PWM_ADDR  = {BLK_PWM, 3'b000};
	localparam logic [IO_ADDR_W-1:0] IRQ_EN    = {BLK_IRQ, 3'b000};
	localparam logic [IO_ADDR_W-1:0] IRQ_VEC   = {BLK_IRQ, 3'b100};   // Entries 0..3
	localparam int BUS_LIMIT  = 2000;  // Cycles a stalled access may wait
	localparam int POLL_LIMIT = 600;   // Status reads per wait

	logic clk, reset, sel, stall, rxd, txd, pwmOut, trap, irq;
	logic [IO_ADDR_W-1:0] addr;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [GPIN_W-1:0] gpin;
	logic [VEC_W-1:0] ivector;

	logic [31:0] seed;
	int checks, errors, timeouts;
	logic [VEC_W-1:0] vecModel [NUM_VECTORS];  // Expected vector table
	logic rxModel;                             // Expected rxValid

	larvaPeripherals uut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus and pin helpers
	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic timedOut(input string what);
		timeouts++;
		$display("Timed out waiting for %s", what);
	endtask

	task automatic tick();
		@(posedge clk);
		#1;  // Drive point after the edge
	endtask

	// Holds the access until stall drops, then commits at the edge
	task automatic busAccess(input logic [IO_ADDR_W-1:0] a, input logic [31:0] d,
		input logic [3:0] strb, output logic [31:0] rd);
		int n;
		sel = 1'b1;
		addr = a;
		wdata = d;
		wstrb = strb;
		n = 0;
		@(negedge clk);
		while (stall && n < BUS_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (stall)
			timedOut("a stalled bus access");
		rd = rdata;  // Combinational, stable mid-cycle
		tick();
		sel = 1'b0;
		wstrb = 4'b0000;
	endtask

	task automatic busWrite(input logic [IO_ADDR_W-1:0] a, input logic [31:0] d,
		input logic [3:0] strb);
		logic [31:0] unused;
		busAccess(a, d, strb, unused);
	endtask

	task automatic busRead(input logic [IO_ADDR_W-1:0] a, output logic [31:0] d);
		busAccess(a, 32'h0, 4'b0000, d);
	endtask

	// One-cycle access that should or should not stall
	task automatic stallProbe(input logic [IO_ADDR_W-1:0] a, input logic [3:0] strb,
		input logic expected, input string name);
		sel = 1'b1;
		addr = a;
		wdata = nextRandom();
		wstrb = strb;
		@(negedge clk);
		compare(name, 32'(expected), 32'(stall));
		tick();
		sel = 1'b0;
		wstrb = 4'b0000;
	endtask

	task automatic waitStatus(input int bitPos, input logic value, input string what);
		logic [31:0] d;
		int n;
		n = 0;
		busRead(UART_STAT, d);
		while (d[bitPos] !== value && n < POLL_LIMIT) begin
			n++;
			busRead(UART_STAT, d);
		end
		if (d[bitPos] !== value)
			timedOut(what);
	endtask

	// 8N1 frame on rxd, LSB first
	task automatic sendFrame(input logic [7:0] data, input logic stopBit);
		logic [FRAME_BITS-1:0] frame;
		frame = {stopBit, data, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++) begin
			rxd = frame[i];
			repeat (BIT_CYCLES) tick();
		end
		rxd = 1'b1;
		repeat (BIT_CYCLES) tick();  // Idle gap
	endtask

	task automatic checkRxStatus(input string name, input logic valid, input logic overrun,
		input logic frameErr);
		logic [31:0] d;
		busRead(UART_STAT, d);
		compare(name, {overrun, frameErr, valid},
			{d[ST_OVERRUN], d[ST_FRAME_ERR], d[ST_RX_VALID]});
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		logic [31:0] r, d;
		logic [7:0] b, duty;
		logic [FRAME_BITS-1:0] frame;
		logic [NUM_IRQ-1:0] en, want, pending;
		logic [1:0] idx;
		logic expIrq;
		int n, high;
		clk = 1'b0;
		reset = 1'b1;
		sel = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = 4'b0000;
		rxd = 1'b1;
		gpin = '0;
		trap = 1'b0;
		seed = 32'h70bc;
		checks = 0;
		errors = 0;
		timeouts = 0;
		rxModel = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		compare("reset txd", 1, txd);
		compare("reset pwmOut", 0, pwmOut);
		compare("reset stall", 0, stall);
		compare("reset irq", 0, irq);
		reset = 1'b0;
		tick();

		// Transmit, with a blocked second write during each frame
		for (int f = 0; f < 3; f++) begin
			waitStatus(ST_TX_READY, 1'b1, "tx ready");
			r = nextRandom();
			b = r[23:16];
			busWrite(UART_DATA, 32'(b), 4'b0001);
			stallProbe(UART_DATA, 4'b0001, 1'b1, "tx busy stall");
			n = 0;
			@(negedge clk);
			while (txd !== 1'b0 && n < 4 * BIT_CYCLES) begin
				n++;
				@(negedge clk);
			end
			if (txd !== 1'b0)
				timedOut("tx start bit");
			repeat (BIT_CYCLES / 2 - 1) @(negedge clk);  // Move to mid-bit
			frame = {1'b1, b, 1'b0};
			for (int i = 0; i < FRAME_BITS; i++) begin
				if (i > 0)
					repeat (BIT_CYCLES) @(negedge clk);
				compare($sformatf("tx bit %0d", i), 32'(frame[i]), 32'(txd));
			end
			tick();
		end

		// Receive: plain frames, overrun, framing error
		stallProbe(UART_DATA, 4'b0000, 1'b1, "rx empty stall");
		for (int f = 0; f < 3; f++) begin
			r = nextRandom();
			sendFrame(r[23:16], 1'b1);
			waitStatus(ST_RX_VALID, 1'b1, "rx valid");
			checkRxStatus("rx status", 1'b1, 1'b0, 1'b0);
			busRead(UART_DATA, d);
			compare("rx data", 32'(r[23:16]), d);
			checkRxStatus("rx status after read", 1'b0, 1'b0, 1'b0);
		end
		r = nextRandom();
		sendFrame(r[7:0], 1'b1);
		sendFrame(r[15:8], 1'b1);  // No read in between
		waitStatus(ST_RX_VALID, 1'b1, "rx valid");
		checkRxStatus("rx overrun", 1'b1, 1'b1, 1'b0);
		busRead(UART_DATA, d);
		compare("rx overrun data", 32'(r[15:8]), d);
		checkRxStatus("rx overrun cleared", 1'b0, 1'b0, 1'b0);
		sendFrame(r[23:16], 1'b0);  // Stop bit low
		waitStatus(ST_RX_VALID, 1'b1, "rx valid");
		checkRxStatus("rx framing error", 1'b1, 1'b0, 1'b1);
		busRead(UART_DATA, d);
		compare("rx framing data", 32'(r[23:16]), d);
		sendFrame(r[31:24], 1'b1);
		waitStatus(ST_RX_VALID, 1'b1, "rx valid");
		checkRxStatus("rx good stop", 1'b1, 1'b0, 1'b0);
		busRead(UART_DATA, d);
		compare("rx data", 32'(r[31:24]), d);

		// PWM duty and period flag
		for (int k = 0; k < 2; k++) begin
			r = nextRandom();
			duty = 8'(1 + r[31:16] % 180);
			busWrite(PWM_ADDR, 32'(duty), 4'b0001);
			waitStatus(ST_PWM_IRQ, 1'b1, "pwm period flag");
			busWrite(PWM_ADDR, 32'(duty), 4'b0001);  // Early in the period
			busRead(UART_STAT, d);
			compare("pwm flag cleared", 0, 32'(d[ST_PWM_IRQ]));
			waitStatus(ST_PWM_IRQ, 1'b1, "pwm new period");
			repeat (PWM_TOP + 1) tick();  // Skip one period
			high = 0;
			repeat (PWM_TOP + 1) begin
				@(negedge clk);
				if (pwmOut)
					high++;
			end
			tick();
			compare("pwm high cycles", 32'(duty), 32'(high));
		end

		////////////////////////////////////////////////////////////
		// Interrupt priority
		for (int i = 0; i < NUM_VECTORS; i++) begin
			r = nextRandom();
			vecModel[i] = r[31:2];
			busWrite(IRQ_VEC + IO_ADDR_W'(i), r, 4'b1111);
		end
		for (int k = 0; k < 10; k++) begin
			r = nextRandom();
			en = r[18:16];
			want = r[22:20];  // Sources {pwm, tx, rx}
			busWrite(IRQ_EN, 32'(en), 4'b0001);
			busRead(IRQ_EN, d);
			compare("irq enable readback", 32'(en), d);
			if (want[0] && !rxModel) begin
				sendFrame(r[7:0], 1'b1);
				waitStatus(ST_RX_VALID, 1'b1, "rx valid");
			end else if (!want[0] && rxModel)
				busRead(UART_DATA, d);
			rxModel = want[0];
			waitStatus(ST_TX_READY, 1'b1, "tx idle");
			busWrite(PWM_ADDR, 32'd90, 4'b0001);
			waitStatus(ST_PWM_IRQ, 1'b1, "pwm flag");
			if (!want[2])
				busWrite(PWM_ADDR, 32'd90, 4'b0001);
			if (!want[1])
				busWrite(UART_DATA, r, 4'b0001);  // Transmitter busy
			trap = r[24];
			@(negedge clk);
			pending = en & want;
			expIrq = r[24] | (|pending);
			idx = r[24] ? 2'd0 : pending[0] ? 2'd1 : pending[1] ? 2'd2 : 2'd3;
			compare("irq line", 32'(expIrq), 32'(irq));
			if (expIrq)
				compare("irq vector", 32'(vecModel[idx]), 32'(ivector));
			tick();
			trap = 1'b0;
		end

		// Input port through the PWM block
		for (int k = 0; k < 4; k++) begin
			r = nextRandom();
			gpin = r[19:16];
			busRead(PWM_ADDR, d);
			compare("gpin read", 32'(r[19:16]), d);
		end

		$display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== uartPkg.sv ====
/*
 * UART line timing and 8N1 frame constants
 */

package uartPkg;

	// Bit timing
	localparam int BIT_CYCLES   = 16;                   // clk cycles per bit
	localparam int BIT_CNT_W    = $clog2(BIT_CYCLES);   // Bit timer width
	localparam int SAMPLE_POINT = 7;                    // Mid-bit sample count

	// Frame layout
	localparam int DATA_BITS   = 8;
	localparam int FRAME_BITS  = 10;                    // start + 8 data + stop
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS + 1);

endpackage

// ==== uartRegsIf.sv ====
/*
 * UART register interface
 * Joins the register map to the transmitter and receiver
 */

`timescale 1ns/100ps

interface uartRegsIf;
	import uartPkg::*;

	logic [DATA_BITS-1:0] txData;  // Byte to send
	logic txWrite;                 // Start of frame
	logic txReady;                 // Transmitter idle
	logic rxRead;                  // Clears valid and overrun
	logic [DATA_BITS-1:0] rxData;  // Last byte received
	logic rxValid;
	logic rxOverrun;
	logic rxFrameErr;

	modport regMap (output txData, txWrite, rxRead,
		input txReady, rxData, rxValid, rxOverrun, rxFrameErr);
	modport transmitter (input txData, txWrite, output txReady);
	modport receiver (input rxRead, output rxData, rxValid, rxOverrun, rxFrameErr);

endinterface

// ==== uartRx.sv ====
/*
 * UART receiver, 8N1
 * Synchronizer, edge-realigned bit timer, frame shift register,
 * receive buffer and valid/overrun flags
 */

`timescale 1ns/100ps

module uartRx (
	input  logic clk,
	input  logic reset,
	uartRegsIf.receiver uart,
	input  logic rxd
);
	import uartPkg::*;

	logic [1:0] rxSync;               // [1] is the stable sample
	logic [BIT_CNT_W-1:0] bitTimer;
	logic rxEdge, sample;
	logic [FRAME_BITS-1:0] shiftReg;
	logic frameDone;
	logic [DATA_BITS:0] rxBuffer;     // stop bit + data
	logic [1:0] rxFlags;              // {overrun, valid}

	// Two-stage synchronizer
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rxSync <= 2'b11;  // Idle line
		else
			rxSync <= {rxSync[0], rxd};
	end

	assign rxEdge = rxSync[1] ^ rxSync[0];

	// Bit timer, realigned on any line edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			bitTimer <= '0;
		else if (rxEdge || bitTimer == BIT_CNT_W'(BIT_CYCLES - 1))
			bitTimer <= '0;
		else
			bitTimer <= bitTimer + 1'b1;
	end

	assign sample = (bitTimer == BIT_CNT_W'(SAMPLE_POINT));  // Middle of the bit

	////////////////////////////////////////////////////////////
	// Frame assembly, done once the start bit hits bit 0
	assign frameDone = ~shiftReg[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shiftReg <= '1;
			rxBuffer <= '1;
			rxFlags  <= 2'b00;
		end else begin
			if (frameDone)
				shiftReg <= '1;  // Restart hunt
			else if (sample)
				shiftReg <= {rxSync[1], shiftReg[FRAME_BITS-1:1]};
			if (frameDone)
				rxBuffer <= shiftReg[FRAME_BITS-1:1];
			if (frameDone)
				rxFlags <= {rxFlags[0], 1'b1};  // Overrun if still valid
			else if (uart.rxRead)
				rxFlags <= 2'b00;
		end
	end

	assign uart.rxData     = rxBuffer[DATA_BITS-1:0];
	assign uart.rxFrameErr = ~rxBuffer[DATA_BITS];  // Stop bit was 0
	assign uart.rxValid    = rxFlags[0];
	assign uart.rxOverrun  = rxFlags[1];

endmodule

// ==== uartTx.sv ====
/*
 * UART transmitter, 8N1
 * Bit timer, 9-bit shift register and frame counter
 */

`timescale 1ns/100ps

module uartTx (
	input  logic clk,
	input  logic reset,
	uartRegsIf.transmitter uart,
	output logic txd
);
	import uartPkg::*;

	logic [BIT_CNT_W-1:0] bitTimer;
	logic bitEnd;
	logic [DATA_BITS:0] shiftReg;      // data + start bit
	logic [FRAME_CNT_W-1:0] frameCnt;  // Bits left, 0 when idle

	assign bitEnd = (bitTimer == BIT_CNT_W'(BIT_CYCLES - 1));

	// Bit timer, restarted by every write
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			bitTimer <= '0;
		else if (uart.txWrite || bitEnd)
			bitTimer <= '0;
		else
			bitTimer <= bitTimer + 1'b1;
	end

	// Shift register, ones shifted in become the stop bit
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			shiftReg <= '1;  // Line idles high
		else if (uart.txWrite)
			shiftReg <= {uart.txData, 1'b0};  // Data plus start bit
		else if (bitEnd)
			shiftReg <= {1'b1, shiftReg[DATA_BITS:1]};
	end

	// Frame counter
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			frameCnt <= '0;
		else if (uart.txWrite)
			frameCnt <= FRAME_CNT_W'(FRAME_BITS);
		else if (bitEnd && frameCnt != '0)
			frameCnt <= frameCnt - 1'b1;
	end

	assign uart.txReady = (frameCnt == '0);
	assign txd = shiftReg[0];  // LSB first

endmodule

// ==== vlog.f ====
larvaIoPkg.sv
uartPkg.sv
uartRegsIf.sv
ioRegisterMap.sv
uartTx.sv
uartRx.sv
pwmGenerator.sv
irqController.sv
larvaPeripherals.sv
larvaPeripherals_sva.sv
tb_larvaPeripherals.sv
